// ==== src/cam_pkg.sv ====
package cam_pkg;

    // ----------------------------------------
    //  Pixel stream types
    // ----------------------------------------

    // Developed pixel: raw, red, green, blue from MSB down
    typedef logic [39:0] pixel_t;

    // One colour lane
    typedef logic [9:0] comp_t;

    // Packed memory word
    typedef logic [31:0] word_t;

    // ----------------------------------------
    //  Output format select
    // ----------------------------------------

    typedef enum logic [2:0] {
        FMT_BGRX8 = 3'd0,   // 8 bit per lane, blue first
        FMT_RGBX8 = 3'd1,   // 8 bit per lane, red first
        FMT_RAW10 = 3'd2,
        FMT_RAW16 = 3'd3,   // Raw lane stretched to 16 bit
        FMT_BGR10 = 3'd4,
        FMT_RGB10 = 3'd5
    } fmt_e;

endpackage

// ==== src/reg_pkg.sv ====
package reg_pkg;

    // ----------------------------------------
    //  Register port
    // ----------------------------------------

    typedef logic [5:0]  reg_addr_t;    // Byte address, index in bits 5..3
    typedef logic [31:0] reg_data_t;

    typedef logic [7:0]  frame_cnt_t;   // Wraps at 256

    // Register indices
    localparam logic [2:0] REG_ID          = 3'd0;
    localparam logic [2:0] REG_SW_RESET    = 3'd1;
    localparam logic [2:0] REG_CAM_ENABLE  = 3'd2;
    localparam logic [2:0] REG_FMT_SELECT  = 3'd3;
    localparam logic [2:0] REG_FRAME_COUNT = 3'd4;

    // Identification word, read only
    localparam reg_data_t ID_VALUE = 32'h0123_4567;

endpackage

// ==== src/cam_ctrl_regs.sv ====
module cam_ctrl_regs
    import cam_pkg::*;
    import reg_pkg::*;
(
    input  logic      axi4s_cam_aclk,
    input  logic      sys_reset,

    // Register port
    input  logic      reg_wr_en_i,
    input  logic      reg_rd_en_i,
    input  reg_addr_t reg_addr_i,
    input  reg_data_t reg_wdata_i,
    output reg_data_t reg_rdata_o,
    output logic      reg_rvalid_o,

    // Pixel path control
    input  logic      frame_start_i,
    output logic      pipe_reset_o,
    output logic      cam_enable_o,
    output fmt_e      fmt_select_o
);

    logic       reg_sw_reset;
    logic       reg_cam_enable;
    fmt_e       reg_fmt_select;
    frame_cnt_t reg_frame_count;
    logic [2:0] reg_index;

    assign reg_index = reg_addr_i[5:3];    // Registers sit 8 bytes apart

    // ----------------------------------------
    //  Control registers
    // ----------------------------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            reg_sw_reset   <= 1'b0;
            reg_cam_enable <= 1'b0;
            reg_fmt_select <= FMT_BGRX8;
        end else if (reg_wr_en_i) begin
            case (reg_index)
                REG_SW_RESET:   reg_sw_reset   <= reg_wdata_i[0];
                REG_CAM_ENABLE: reg_cam_enable <= reg_wdata_i[0];
                REG_FMT_SELECT: reg_fmt_select <= fmt_e'(reg_wdata_i[2:0]);
                default: ;  // ID and frame count are read only
            endcase
        end
    end

    // Counts accepted frame starts, soft reset leaves it alone
    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            reg_frame_count <= '0;
        end else if (frame_start_i) begin
            reg_frame_count <= reg_frame_count + 1'b1;
        end
    end

    // ----------------------------------------
    //  Read port
    // ----------------------------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            reg_rvalid_o <= 1'b0;
        end else begin
            reg_rvalid_o <= reg_rd_en_i;   // One cycle pulse per request
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (reg_rd_en_i) begin
            case (reg_index)
                REG_ID:          reg_rdata_o <= ID_VALUE;
                REG_SW_RESET:    reg_rdata_o <= reg_data_t'(reg_sw_reset);
                REG_CAM_ENABLE:  reg_rdata_o <= reg_data_t'(reg_cam_enable);
                REG_FMT_SELECT:  reg_rdata_o <= reg_data_t'(reg_fmt_select);
                REG_FRAME_COUNT: reg_rdata_o <= reg_data_t'(reg_frame_count);
                default:         reg_rdata_o <= '0;
            endcase
        end
    end

    // ----------------------------------------
    //  Pipe reset and outputs
    // ----------------------------------------

    // Registered so the pixel path sees one clean reset net
    always_ff @(posedge axi4s_cam_aclk) begin
        pipe_reset_o <= sys_reset | reg_sw_reset;
    end

    assign cam_enable_o = reg_cam_enable;
    assign fmt_select_o = reg_fmt_select;

endmodule

// ==== src/pixel_fifo.sv ====
module pixel_fifo
    import cam_pkg::*;
#(
    parameter int FIFO_PTR_BITS = 4    // Depth is 2**FIFO_PTR_BITS
) (
    input  logic   axi4s_cam_aclk,
    input  logic   pipe_reset_i,

    // Input stream
    input  pixel_t s_tdata_i,
    input  logic   s_tuser_i,
    input  logic   s_tlast_i,
    input  logic   s_tvalid_i,
    output logic   s_tready_o,

    // Output stream
    output pixel_t m_tdata_o,
    output logic   m_tuser_o,
    output logic   m_tlast_o,
    output logic   m_tvalid_o,
    input  logic   m_tready_i,

    output logic   frame_start_o
);

    localparam int DEPTH = 2 ** FIFO_PTR_BITS;

    // Entry holds tuser, tlast and the pixel
    logic [41:0] mem [DEPTH];

    logic [FIFO_PTR_BITS:0] wr_ptr;    // Extra bit tells full from empty
    logic [FIFO_PTR_BITS:0] rd_ptr;
    logic                   fifo_run;
    logic                   full;
    logic                   empty;
    logic                   push;
    logic                   pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_PTR_BITS] != rd_ptr[FIFO_PTR_BITS]) &&
                   (wr_ptr[FIFO_PTR_BITS-1:0] == rd_ptr[FIFO_PTR_BITS-1:0]);

    assign s_tready_o = fifo_run && !full;
    assign push       = s_tvalid_i && s_tready_o;
    assign pop        = m_tvalid_o && m_tready_i;

    // ----------------------------------------
    //  Pointers
    // ----------------------------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (pipe_reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_run <= 1'b0;
        end else begin
            fifo_run <= 1'b1;    // Ready opens one cycle after reset
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (push) begin
            mem[wr_ptr[FIFO_PTR_BITS-1:0]] <= {s_tuser_i, s_tlast_i, s_tdata_i};
        end
    end

    // Head of the buffer, read without a register
    assign {m_tuser_o, m_tlast_o, m_tdata_o} = mem[rd_ptr[FIFO_PTR_BITS-1:0]];
    assign m_tvalid_o = !empty;

    assign frame_start_o = push && s_tuser_i;    // Start of frame taken in

endmodule

// ==== src/pixel_packer.sv ====
module pixel_packer
    import cam_pkg::*;
(
    input  logic   axi4s_cam_aclk,
    input  logic   pipe_reset_i,
    input  fmt_e   fmt_select_i,

    // Pixel side
    input  pixel_t s_tdata_i,
    input  logic   s_tuser_i,
    input  logic   s_tlast_i,
    input  logic   s_tvalid_i,
    output logic   s_tready_o,

    // Memory word side
    output word_t  m_tdata_o,
    output logic   m_tuser_o,
    output logic   m_tlast_o,
    output logic   m_tvalid_o,
    input  logic   m_tready_i
);

    comp_t blue;
    comp_t green;
    comp_t red;
    comp_t raw;
    word_t packed_word;
    logic  load;

    assign blue  = s_tdata_i[9:0];
    assign green = s_tdata_i[19:10];
    assign red   = s_tdata_i[29:20];
    assign raw   = s_tdata_i[39:30];

    // ----------------------------------------
    //  Lane mapping, byte 0 is the LSB
    // ----------------------------------------

    always_comb begin
        case (fmt_select_i)
            FMT_BGRX8: packed_word = {raw[9:2], red[9:2], green[9:2], blue[9:2]};
            FMT_RGBX8: packed_word = {raw[9:2], blue[9:2], green[9:2], red[9:2]};
            FMT_RAW10: packed_word = {22'd0, raw};
            FMT_RAW16: packed_word = {16'd0, raw, raw[9:4]};    // MSBs repeated
            FMT_BGR10: packed_word = {2'b00, red, green, blue};
            FMT_RGB10: packed_word = {2'b00, blue, green, red};
            default:   packed_word = '0;    // Codes 6 and 7
        endcase
    end

    // ----------------------------------------
    //  Output register
    // ----------------------------------------

    // Takes a beat when empty or when the held one leaves
    assign s_tready_o = !m_tvalid_o || m_tready_i;
    assign load       = s_tvalid_i && s_tready_o;

    always_ff @(posedge axi4s_cam_aclk) begin
        if (pipe_reset_i) begin
            m_tvalid_o <= 1'b0;
        end else if (load) begin
            m_tvalid_o <= 1'b1;
        end else if (m_tready_i) begin
            m_tvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (load) begin
            m_tdata_o <= packed_word;
            m_tuser_o <= s_tuser_i;
            m_tlast_o <= s_tlast_i;
        end
    end

endmodule

// ==== src/cam_capture_top.sv ====
module cam_capture_top
    import cam_pkg::*;
    import reg_pkg::*;
#(
    parameter int FIFO_PTR_BITS = 4
) (
    input  logic      axi4s_cam_aclk,
    input  logic      sys_reset,

    // Register port
    input  logic      reg_wr_en_i,
    input  logic      reg_rd_en_i,
    input  reg_addr_t reg_addr_i,
    input  reg_data_t reg_wdata_i,
    output reg_data_t reg_rdata_o,
    output logic      reg_rvalid_o,

    // Developed pixels in
    input  pixel_t    s_tdata_i,
    input  logic      s_tuser_i,
    input  logic      s_tlast_i,
    input  logic      s_tvalid_i,
    output logic      s_tready_o,

    // Packed words out
    output word_t     m_tdata_o,
    output logic      m_tuser_o,
    output logic      m_tlast_o,
    output logic      m_tvalid_o,
    input  logic      m_tready_i,

    output logic      cam_enable_o
);

    logic   pipe_reset;
    logic   frame_start;
    fmt_e   fmt_select;

    // FIFO to packer
    pixel_t fifo_tdata;
    logic   fifo_tuser;
    logic   fifo_tlast;
    logic   fifo_tvalid;
    logic   fifo_tready;

    cam_ctrl_regs u_regs (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .reg_wr_en_i    (reg_wr_en_i),
        .reg_rd_en_i    (reg_rd_en_i),
        .reg_addr_i     (reg_addr_i),
        .reg_wdata_i    (reg_wdata_i),
        .reg_rdata_o    (reg_rdata_o),
        .reg_rvalid_o   (reg_rvalid_o),
        .frame_start_i  (frame_start),
        .pipe_reset_o   (pipe_reset),
        .cam_enable_o   (cam_enable_o),
        .fmt_select_o   (fmt_select)
    );

    pixel_fifo #(
        .FIFO_PTR_BITS  (FIFO_PTR_BITS)
    ) u_fifo (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .pipe_reset_i   (pipe_reset),
        .s_tdata_i      (s_tdata_i),
        .s_tuser_i      (s_tuser_i),
        .s_tlast_i      (s_tlast_i),
        .s_tvalid_i     (s_tvalid_i),
        .s_tready_o     (s_tready_o),
        .m_tdata_o      (fifo_tdata),
        .m_tuser_o      (fifo_tuser),
        .m_tlast_o      (fifo_tlast),
        .m_tvalid_o     (fifo_tvalid),
        .m_tready_i     (fifo_tready),
        .frame_start_o  (frame_start)
    );

    pixel_packer u_packer (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .pipe_reset_i   (pipe_reset),
        .fmt_select_i   (fmt_select),
        .s_tdata_i      (fifo_tdata),
        .s_tuser_i      (fifo_tuser),
        .s_tlast_i      (fifo_tlast),
        .s_tvalid_i     (fifo_tvalid),
        .s_tready_o     (fifo_tready),
        .m_tdata_o      (m_tdata_o),
        .m_tuser_o      (m_tuser_o),
        .m_tlast_o      (m_tlast_o),
        .m_tvalid_o     (m_tvalid_o),
        .m_tready_i     (m_tready_i)
    );

endmodule

// ==== test/tb_cam_capture.sv ====
module tb_cam_capture
    import cam_pkg::*;
    import reg_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_LEN   = 12;
    localparam int BURST_LEN  = 40;    // Longer than the 16 entry FIFO
    localparam int FRAME_RUNS = 250;   // Enough to wrap the frame counter
    localparam int TOTAL_BEATS = 8 * LINE_LEN + BURST_LEN + FRAME_RUNS + 2 * LINE_LEN;
    localparam int DRAIN_CYCLES = 20 * BURST_LEN;
    localparam longint WATCHDOG_NS = longint'(TOTAL_BEATS) * 20 * 100 + 50_000;

    logic      axi4s_cam_aclk;
    logic      sys_reset;
    logic      reg_wr_en_i;
    logic      reg_rd_en_i;
    reg_addr_t reg_addr_i;
    reg_data_t reg_wdata_i;
    reg_data_t reg_rdata_o;
    logic      reg_rvalid_o;
    pixel_t    s_tdata_i;
    logic      s_tuser_i;
    logic      s_tlast_i;
    logic      s_tvalid_i;
    logic      s_tready_o;
    word_t     m_tdata_o;
    logic      m_tuser_o;
    logic      m_tlast_o;
    logic      m_tvalid_o;
    logic      m_tready_i;
    logic      cam_enable_o;

    logic [33:0] exp_q[$];    // {tuser, tlast, word}
    logic [33:0] exp_beat;
    logic [2:0]  cur_fmt;
    int          ready_mode;  // 0 low, 1 high, 2 random
    int          error_count;
    int          pass_count;
    int          fail_count;
    int          frames_sent;
    int          test_start;
    logic        hold_prev;
    word_t       held_data;

    cam_capture_top uut (.*);

    initial begin
        axi4s_cam_aclk = 1'b0;
        forever #50 axi4s_cam_aclk = ~axi4s_cam_aclk;
    end

    // ----------------------------------------
    //  Reference model
    // ----------------------------------------

    function automatic word_t pack_word(input logic [2:0] fmt, input pixel_t px);
        comp_t b;
        comp_t g;
        comp_t r;
        comp_t w;
        word_t res;
        b = px[9:0];
        g = px[19:10];
        r = px[29:20];
        w = px[39:30];
        res = '0;
        case (fmt)
            3'd0: begin
                res[7:0] = b[9:2];
                res[15:8] = g[9:2];
                res[23:16] = r[9:2];
                res[31:24] = w[9:2];
            end
            3'd1: begin
                res[7:0] = r[9:2];
                res[15:8] = g[9:2];
                res[23:16] = b[9:2];
                res[31:24] = w[9:2];
            end
            3'd2: res[9:0] = w;
            3'd3: begin
                res[15:6] = w;         // Raw on top with its MSBs below
                res[5:0] = w[9:4];
            end
            3'd4: begin
                res[9:0] = b;
                res[19:10] = g;
                res[29:20] = r;
            end
            3'd5: begin
                res[9:0] = r;
                res[19:10] = g;
                res[29:20] = b;
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    // ----------------------------------------
    //  Drivers
    // ----------------------------------------

    task automatic reg_write(input logic [2:0] idx, input reg_data_t data);
        reg_addr_i  <= {idx, 3'b000};
        reg_wdata_i <= data;
        reg_wr_en_i <= 1'b1;
        @(posedge axi4s_cam_aclk);
        reg_wr_en_i <= 1'b0;
    endtask

    task automatic check_reg(input logic [2:0] idx, input reg_data_t expected);
        reg_addr_i  <= {idx, 3'b000};
        reg_rd_en_i <= 1'b1;
        @(posedge axi4s_cam_aclk);
        reg_rd_en_i <= 1'b0;
        if (reg_rvalid_o) begin
            $display("reg_rvalid_o was already high when register %0d was requested", idx);
            error_count++;
        end
        @(posedge axi4s_cam_aclk);
        if (!reg_rvalid_o) begin
            $display("read of register %0d gave no reg_rvalid_o pulse", idx);
            error_count++;
        end else if (reg_rdata_o !== expected) begin
            $display("mismatch reg_rdata_o reg %0d expected %h actual %h",
                     idx, expected, reg_rdata_o);
            error_count++;
        end
    endtask

    task automatic send_beat(input pixel_t px, input logic user, input logic last);
        s_tdata_i  <= px;
        s_tuser_i  <= user;
        s_tlast_i  <= last;
        s_tvalid_i <= 1'b1;
        @(posedge axi4s_cam_aclk);
        while (!s_tready_o) @(posedge axi4s_cam_aclk);
        exp_q.push_back({user, last, pack_word(cur_fmt, px)});
        if (user) frames_sent++;
    endtask

    task automatic send_line(input int len);
        for (int i = 0; i < len; i++) begin
            send_beat(pixel_t'({$urandom(), $urandom()}), i == 0, i == len - 1);
        end
        s_tvalid_i <= 1'b0;
    endtask

    task automatic wait_drain;
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge axi4s_cam_aclk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected output beats never arrived", exp_q.size());
            error_count++;
            exp_q.delete();
        end
        repeat (2) @(posedge axi4s_cam_aclk);
    endtask

    task automatic end_test(input string name);
        if (error_count == test_start) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s (%0d errors)", name, error_count - test_start);
        end
        test_start = error_count;
    endtask

    // Output ready pattern
    always @(posedge axi4s_cam_aclk) begin
        case (ready_mode)
            0:       m_tready_i <= 1'b0;
            1:       m_tready_i <= 1'b1;
            default: m_tready_i <= ($urandom() % 2) == 1;
        endcase
    end

    // ----------------------------------------
    //  Scoreboard
    // ----------------------------------------

    always @(posedge axi4s_cam_aclk) begin
        if (!sys_reset) begin
            if (hold_prev && m_tdata_o !== held_data) begin
                $display("mismatch m_tdata_o held %h changed to %h", held_data, m_tdata_o);
                error_count++;
            end
            if (m_tvalid_o && m_tready_i) begin
                if (exp_q.size() == 0) begin
                    $display("output beat %h arrived with no word expected", m_tdata_o);
                    error_count++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    if (m_tdata_o !== exp_beat[31:0]) begin
                        $display("mismatch m_tdata_o expected %h actual %h",
                                 exp_beat[31:0], m_tdata_o);
                        error_count++;
                    end
                    if (m_tuser_o !== exp_beat[33]) begin
                        $display("mismatch m_tuser_o expected %h actual %h",
                                 exp_beat[33], m_tuser_o);
                        error_count++;
                    end
                    if (m_tlast_o !== exp_beat[32]) begin
                        $display("mismatch m_tlast_o expected %h actual %h",
                                 exp_beat[32], m_tlast_o);
                        error_count++;
                    end
                end
            end
        end
        hold_prev <= m_tvalid_o && !m_tready_i;
        held_data <= m_tdata_o;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    // ----------------------------------------
    //  Test sequence
    // ----------------------------------------

    initial begin
        void'($urandom(37));
        sys_reset   = 1'b1;
        reg_wr_en_i = 1'b0;
        reg_rd_en_i = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        s_tdata_i   = '0;
        s_tuser_i   = 1'b0;
        s_tlast_i   = 1'b0;
        s_tvalid_i  = 1'b0;
        m_tready_i  = 1'b0;
        ready_mode  = 1;
        cur_fmt     = 3'd0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        frames_sent = 0;
        test_start  = 0;
        hold_prev   = 1'b0;
        held_data   = '0;
        repeat (5) @(posedge axi4s_cam_aclk);
        sys_reset <= 1'b0;
        @(posedge axi4s_cam_aclk);

        // Reset values
        check_reg(3'd0, 32'h0123_4567);
        for (int i = 1; i <= 4; i++) check_reg(3'(i), 32'h0);
        if (cam_enable_o !== 1'b0) begin
            $display("mismatch cam_enable_o expected 0 actual %h", cam_enable_o);
            error_count++;
        end
        end_test("register reset values");

        reg_write(3'd1, 32'h0000_0003);
        check_reg(3'd1, 32'h1);
        reg_write(3'd1, 32'h0);
        check_reg(3'd1, 32'h0);
        reg_write(3'd2, 32'hFFFF_FFFF);
        @(posedge axi4s_cam_aclk);
        if (cam_enable_o !== 1'b1) begin
            $display("mismatch cam_enable_o expected 1 actual %h", cam_enable_o);
            error_count++;
        end
        check_reg(3'd2, 32'h1);
        reg_write(3'd3, 32'h0000_00FA);
        check_reg(3'd3, 32'h2);
        reg_write(3'd0, 32'hDEAD_BEEF);    // ID is read only
        check_reg(3'd0, 32'h0123_4567);
        end_test("register write and read back");
        while (!s_tready_o) @(posedge axi4s_cam_aclk);

        for (int f = 0; f < 8; f++) begin
            cur_fmt = 3'(f);
            reg_write(3'd3, reg_data_t'(f));
            send_line(LINE_LEN);
            wait_drain();
            end_test($sformatf("stream format %0d", f));
        end

        // Random back-pressure
        cur_fmt = 3'd5;
        reg_write(3'd3, 32'h5);
        ready_mode = 2;
        send_line(BURST_LEN);
        wait_drain();
        ready_mode = 1;
        end_test("burst with random ready");

        for (int i = 0; i < FRAME_RUNS; i++) send_beat(pixel_t'(i), 1'b1, 1'b1);
        s_tvalid_i <= 1'b0;
        wait_drain();
        check_reg(3'd4, reg_data_t'(frames_sent % 256));
        end_test("frame counter");

        // Soft reset with beats held in the pipe
        cur_fmt = 3'd0;
        reg_write(3'd3, 32'h0);
        ready_mode = 0;
        send_line(8);
        reg_write(3'd1, 32'h1);
        repeat (4) @(posedge axi4s_cam_aclk);
        if (s_tready_o !== 1'b0 || m_tvalid_o !== 1'b0) begin
            $display("Soft reset did not drop s_tready_o and m_tvalid_o");
            error_count++;
        end
        exp_q.delete();
        reg_write(3'd1, 32'h0);
        ready_mode = 1;
        while (!s_tready_o) @(posedge axi4s_cam_aclk);
        send_line(LINE_LEN);
        wait_drain();
        end_test("soft reset and restart");

        $display("Tests passed %0d, failed %0d, errors %0d", pass_count, fail_count,
                 error_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
src/cam_pkg.sv
src/reg_pkg.sv
src/cam_ctrl_regs.sv
src/pixel_fifo.sv
src/pixel_packer.sv
src/cam_capture_top.sv
test/tb_cam_capture.sv
